/* list.f */
+incdir+src
src/decomp_pkg.sv
src/lane_wr_if.sv
src/ahb_burst_master.sv
src/beat_packer.sv
src/decomp_dma_top.sv
verif/ahb_mem_model.sv
verif/decomp_dma_tb.sv

/* Makefile */
SIM  := obj_dir/Vdecomp_dma_tb
SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module decomp_dma_tb -Mdir obj_dir

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* verif/decomp_dma_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decomp_defs.svh"

module decomp_dma_tb;

    localparam int NUM_ROWS    = 4;
    localparam int CAP_SIZE    = 64;
    localparam int CYC_PER_BLK = 200;

    // --------------------
    // test table
    // --------------------
    // forced header bits [31:30] per block, two bits each and block 0 lowest
    string       row_name  [NUM_ROWS] = '{"one_block", "three_blocks_stalled",
                                          "zero_length", "four_blocks_stalled"};
    logic [31:0] row_src   [NUM_ROWS] = '{32'h0100, 32'h0400, 32'h0800, 32'h0900};
    logic [31:0] row_dst   [NUM_ROWS] = '{32'h2000, 32'h2400, 32'h2800, 32'h3000};
    int          row_len   [NUM_ROWS] = '{1, 3, 0, 4};
    logic        row_stall [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic [15:0] row_hdr   [NUM_ROWS] = '{16'h0003, 16'h0024, 16'h0000, 16'h00B1};

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [`DECOMP_ADDR_W-1:0]  src_addr;
    logic [`DECOMP_ADDR_W-1:0]  dst_addr;
    logic [`DECOMP_LEN_W-1:0]   len;
    logic                       start;
    logic                       done;
    logic                       hbusreq;
    logic                       hgrant;
    logic [31:0]                haddr;
    logic [1:0]                 htrans;
    logic                       hwrite;
    logic [31:0]                hwdata;
    logic                       hready;
    logic [31:0]                hrdata;
    logic                       wren0;
    logic                       wren1;
    logic                       wren2;
    logic                       sop;
    logic                       eop;
    logic [63:0]                lane_wdata;
    logic                       decomp_done = 1'b0;
    logic [3:0]                 buf_addr;
    logic [63:0]                decomp_data;
    logic [63:0]                out_buf [0:15];
    logic                       stall_en;
    logic                       hdr_wr;
    logic [31:0]                hdr_addr;
    logic [1:0]                 hdr_bits;

    logic [2:0]                 cap_wren [0:CAP_SIZE-1];
    logic                       cap_sop  [0:CAP_SIZE-1];
    logic                       cap_eop  [0:CAP_SIZE-1];
    logic [63:0]                cap_data [0:CAP_SIZE-1];
    int                         cap_cnt = 0;
    int                         eop_cnt = 0;
    int                         done_wait = 0;
    int                         cur_row = 0;
    string                      cur_name;
    int                         row_errs = 0;
    int                         total_errs = 0;
    int                         rows_failed = 0;
    int                         cycle_cnt = 0;
    int                         limit;

    decomp_dma_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr),
        .dst_addr_i     (dst_addr),
        .len_i          (len),
        .start_i        (start),
        .done_o         (done),
        .hbusreq_o      (hbusreq),
        .hgrant_i       (hgrant),
        .haddr_o        (haddr),
        .htrans_o       (htrans),
        .hwrite_o       (hwrite),
        .hwdata_o       (hwdata),
        .hready_i       (hready),
        .hrdata_i       (hrdata),
        .decomp0_wren_o (wren0),
        .decomp1_wren_o (wren1),
        .decomp2_wren_o (wren2),
        .decomp_sop_o   (sop),
        .decomp_eop_o   (eop),
        .decomp_wdata_o (lane_wdata),
        .decomp_done_i  (decomp_done),
        .buf_addr_o     (buf_addr),
        .decomp_data_i  (decomp_data)
    );

    ahb_mem_model u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_en_i (stall_en),
        .hbusreq_i  (hbusreq),
        .hgrant_o   (hgrant),
        .haddr_i    (haddr),
        .htrans_i   (htrans),
        .hwrite_i   (hwrite),
        .hwdata_i   (hwdata),
        .hready_o   (hready),
        .hrdata_o   (hrdata),
        .hdr_wr_i   (hdr_wr),
        .hdr_addr_i (hdr_addr),
        .hdr_bits_i (hdr_bits)
    );

    always #20 clk = ~clk;

    // output buffer answers in the same cycle
    assign decomp_data = out_buf[buf_addr];

    // bit 31 picks lane 0, else bit 30 clear picks lane 1
    function automatic int lane_for_header(input logic [1:0] hdr);
        if (hdr[1]) begin
            return 0;
        end else if (!hdr[0]) begin
            return 1;
        end
        return 2;
    endfunction

    // both halves carry row, block and the whole buffer address
    function automatic logic [63:0] buffer_word(input int row, input int blk,
                                                input logic [3:0] a);
        logic [31:0] upper;
        upper = {4'hB, 4'(row), 12'(blk), 8'h5A, a};
        return {upper, ~upper};
    endfunction

    task automatic compare_word(input string what, input logic [63:0] exp,
                                input logic [63:0] got);
        assert (got === exp) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_name, what, exp, got);
            row_errs = row_errs + 1;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("Error in %s: %s", cur_name, msg);
            row_errs = row_errs + 1;
        end
    endtask

    // --------------------
    // monitors and decoder model
    // --------------------
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (wren0 || wren1 || wren2 || sop || eop) begin
            if (cap_cnt < CAP_SIZE) begin
                cap_wren[cap_cnt] = {wren2, wren1, wren0};
                cap_sop[cap_cnt]  = sop;
                cap_eop[cap_cnt]  = eop;
                cap_data[cap_cnt] = lane_wdata;
            end
            cap_cnt = cap_cnt + 1;
        end
    end

    // expanded data ready at eop and done a few cycles later
    always @(negedge clk) begin
        decomp_done = 1'b0;
        if (eop) begin
            for (int a = 0; a < 16; a++) begin
                out_buf[a] = buffer_word(cur_row, eop_cnt, 4'(a));
            end
            eop_cnt   = eop_cnt + 1;
            done_wait = 3;
        end else if (done_wait != 0) begin
            done_wait = done_wait - 1;
            if (done_wait == 0) begin
                decomp_done = 1'b1;
            end
        end
    end

    // --------------------
    // checks per row
    // --------------------
    task automatic scan_bus_log(input int r, input int base);
        int          n_rd;
        int          n_wr;
        logic [31:0] exp_addr;
        logic [63:0] bw;
        logic [31:0] exp_half;
        n_rd = 0;
        n_wr = 0;
        for (int i = base; i < u_mem.log_cnt; i++) begin
            if (u_mem.log_wr[i]) begin
                exp_addr = row_dst[r] + 32'(128 * (n_wr / 32) + 4 * (n_wr % 32));
                bw       = buffer_word(r, n_wr / 32, 4'((n_wr % 32) / 2));
                exp_half = (n_wr % 2 == 1) ? bw[31:0] : bw[63:32];
                compare_word($sformatf("write %0d address", n_wr), 64'(exp_addr),
                             64'(u_mem.log_addr[i]));
                compare_word($sformatf("write %0d data", n_wr), 64'(exp_half),
                             64'(u_mem.log_data[i]));
                n_wr = n_wr + 1;
            end else begin
                exp_addr = row_src[r] + 32'(64 * (n_rd / 16) + 4 * (n_rd % 16));
                compare_word($sformatf("read %0d address", n_rd), 64'(exp_addr),
                             64'(u_mem.log_addr[i]));
                n_rd = n_rd + 1;
            end
        end
        compare_word("read beat count", 64'(16 * row_len[r]), 64'(n_rd));
        compare_word("write beat count", 64'(32 * row_len[r]), 64'(n_wr));
    endtask

    task automatic inspect_lanes(input int r);
        int          b;
        int          j;
        int          lane;
        logic [31:0] hi_addr;
        logic [63:0] exp_word;
        compare_word("packed word count", 64'(8 * row_len[r]), 64'(cap_cnt));
        compare_word("decoded block count", 64'(row_len[r]), 64'(eop_cnt));
        for (int w = 0; w < cap_cnt && w < CAP_SIZE; w++) begin
            b = w / 8;
            j = w % 8;
            lane = lane_for_header(row_hdr[r][2 * b +: 2]);
            compare_word($sformatf("lane strobes of word %0d", w), 64'(3'b001 << lane),
                         64'(cap_wren[w]));
            hi_addr  = row_src[r] + 32'(64 * b + 8 * j);
            exp_word = {u_mem.mem[hi_addr[13:2]], u_mem.mem[hi_addr[13:2] + 12'd1]};
            compare_word($sformatf("data of word %0d", w), exp_word, cap_data[w]);
            compare_word($sformatf("sop of word %0d", w), 64'(j == 0), 64'(cap_sop[w]));
            compare_word($sformatf("eop of word %0d", w), 64'(j == 7), 64'(cap_eop[w]));
        end
    endtask

    task automatic verify_writeback(input int r);
        logic [31:0] addr;
        logic [63:0] bw;
        logic [31:0] exp_half;
        for (int b = 0; b < row_len[r]; b++) begin
            for (int k = 0; k < 32; k++) begin
                addr     = row_dst[r] + 32'(128 * b + 4 * k);
                bw       = buffer_word(r, b, 4'(k / 2));
                exp_half = (k % 2 == 1) ? bw[31:0] : bw[63:32];
                compare_word($sformatf("write block %0d beat %0d", b, k), 64'(exp_half),
                             64'(u_mem.mem[addr[13:2]]));
            end
        end
    endtask

    task automatic apply_row(input int r);
        int log_base;
        @(negedge clk);
        cur_name = row_name[r];
        cur_row  = r;
        row_errs = 0;
        cap_cnt  = 0;
        eop_cnt  = 0;
        log_base = u_mem.log_cnt;
        stall_en = row_stall[r];
        for (int b = 0; b < row_len[r]; b++) begin
            @(negedge clk);
            hdr_wr   = 1'b1;
            hdr_addr = row_src[r] + 32'(64 * b);
            hdr_bits = row_hdr[r][2 * b +: 2];
        end
        @(negedge clk);
        hdr_wr   = 1'b0;
        src_addr = row_src[r];
        dst_addr = row_dst[r];
        len      = `DECOMP_LEN_W'(row_len[r]);
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (row_len[r] == 0) begin
            repeat (20) begin
                @(posedge clk);
                expect_true(!hbusreq, "bus request raised for a zero-length start");
                expect_true(done, "done_o dropped for a zero-length start");
            end
            compare_word("packed word count", 64'd0, 64'(cap_cnt));
        end else begin
            @(posedge clk);
            expect_true(!done, "done_o stayed high after start");
            while (!done) begin
                @(posedge clk);
            end
            scan_bus_log(r, log_base);
            inspect_lanes(r);
            verify_writeback(r);
        end
        $display("%s: %s (%0d errors)", cur_name, (row_errs == 0) ? "ok" : "failed", row_errs);
        total_errs = total_errs + row_errs;
        if (row_errs != 0) begin
            rows_failed = rows_failed + 1;
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_n    = 1'b0;
        src_addr = '0;
        dst_addr = '0;
        len      = '0;
        start    = 1'b0;
        stall_en = 1'b0;
        hdr_wr   = 1'b0;
        hdr_addr = '0;
        hdr_bits = '0;
        for (int a = 0; a < 16; a++) begin
            out_buf[a] = '0;
        end
        limit = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + row_len[r] * CYC_PER_BLK;
        end
        repeat (16) @(negedge clk);
        cur_name = "reset";
        expect_true(done && !hbusreq && !hwrite && (htrans == 2'b00),
                    "bus outputs not idle in reset");
        expect_true(!(wren0 || wren1 || wren2 || sop || eop), "lane strobes high in reset");
        $display("%s: %s (%0d errors)", cur_name, (row_errs == 0) ? "ok" : "failed", row_errs);
        total_errs = total_errs + row_errs;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("summary: %0d rows passed, %0d rows failed, %0d errors",
                 NUM_ROWS - rows_failed, rows_failed, total_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ahb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module ahb_mem_model #(
    parameter int WORDS    = 4096,
    parameter int LOG_SIZE = 1024
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         stall_en_i,
    input  wire         hbusreq_i,
    output logic        hgrant_o,
    input  wire  [31:0] haddr_i,
    input  wire  [1:0]  htrans_i,
    input  wire         hwrite_i,
    input  wire  [31:0] hwdata_i,
    output logic        hready_o,
    output logic [31:0] hrdata_o,
    input  wire         hdr_wr_i,
    input  wire  [31:0] hdr_addr_i,
    input  wire  [1:0]  hdr_bits_i
);

    logic [31:0] mem      [0:WORDS-1];
    // completed transfers in bus order
    logic [31:0] log_addr [0:LOG_SIZE-1];
    logic [31:0] log_data [0:LOG_SIZE-1];
    logic        log_wr   [0:LOG_SIZE-1];
    int          log_cnt = 0;

    integer      seed;
    logic [31:0] draw;
    int          grant_wait = 0;
    logic        grant = 1'b0;
    logic        ready = 1'b1;
    logic        stall_q = 1'b0;
    logic        dp_valid = 1'b0;
    logic        dp_write = 1'b0;
    logic [31:0] dp_addr = '0;

    initial begin
        seed = 47;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = $random(seed);
        end
    end

    assign hgrant_o = grant;
    assign hready_o = ready;
    assign hrdata_o = mem[dp_addr[13:2]];

    // --------------------
    // address and data phases
    // --------------------
    always @(posedge clk) begin
        stall_q <= stall_en_i;
        if (hdr_wr_i) begin
            mem[hdr_addr_i[13:2]][31:30] <= hdr_bits_i;
        end
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_addr  <= '0;
            log_cnt  <= 0;
        end else if (ready) begin
            if (dp_valid) begin
                if (dp_write) begin
                    mem[dp_addr[13:2]] <= hwdata_i;
                end
                if (log_cnt < LOG_SIZE) begin
                    log_addr[log_cnt] <= dp_addr;
                    log_data[log_cnt] <= dp_write ? hwdata_i : hrdata_o;
                    log_wr[log_cnt]   <= dp_write;
                end
                log_cnt <= log_cnt + 1;
            end
            // NONSEQ and SEQ both have bit 1 set
            dp_valid <= htrans_i[1];
            dp_write <= hwrite_i;
            dp_addr  <= haddr_i;
        end
    end

    // grant three cycles after the request and random wait states
    always @(negedge clk) begin
        // one draw per cycle so the stall pattern is fixed by the seed
        draw  = $random(seed);
        ready = !stall_q || (draw[1:0] != 2'b00);
        if (!hbusreq_i) begin
            grant      = 1'b0;
            grant_wait = 0;
        end else if (!grant) begin
            if (grant_wait >= 2) begin
                grant = 1'b1;
            end else begin
                grant_wait = grant_wait + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/decomp_dma_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decomp_defs.svh"

module decomp_dma_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [`DECOMP_ADDR_W-1:0]   src_addr_i,
    input  wire  [`DECOMP_ADDR_W-1:0]   dst_addr_i,
    input  wire  [`DECOMP_LEN_W-1:0]    len_i,
    input  wire                         start_i,
    output logic                        done_o,

    // AHB master
    output logic                        hbusreq_o,
    input  wire                         hgrant_i,
    output logic [`DECOMP_ADDR_W-1:0]   haddr_o,
    output decomp_pkg::ahb_trans_e      htrans_o,
    output logic                        hwrite_o,
    output logic [`DECOMP_DATA_W-1:0]   hwdata_o,
    input  wire                         hready_i,
    input  wire  [`DECOMP_DATA_W-1:0]   hrdata_i,

    // decoder lanes
    output logic                        decomp0_wren_o,
    output logic                        decomp1_wren_o,
    output logic                        decomp2_wren_o,
    output logic                        decomp_sop_o,
    output logic                        decomp_eop_o,
    output logic [`DECOMP_WORD_W-1:0]   decomp_wdata_o,
    input  wire                         decomp_done_i,

    // output buffer
    output logic [`DECOMP_BUF_AW-1:0]   buf_addr_o,
    input  wire  [`DECOMP_WORD_W-1:0]   decomp_data_i
);

    logic       beat_en;
    logic [4:0] beat_idx;

    lane_wr_if lane_wr ();

    ahb_burst_master u_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr_i),
        .dst_addr_i    (dst_addr_i),
        .len_i         (len_i),
        .start_i       (start_i),
        .decomp_done_i (decomp_done_i),
        .decomp_data_i (decomp_data_i),
        .hgrant_i      (hgrant_i),
        .hready_i      (hready_i),
        .done_o        (done_o),
        .hbusreq_o     (hbusreq_o),
        .haddr_o       (haddr_o),
        .htrans_o      (htrans_o),
        .hwrite_o      (hwrite_o),
        .hwdata_o      (hwdata_o),
        .buf_addr_o    (buf_addr_o),
        .beat_en_o     (beat_en),
        .beat_idx_o    (beat_idx)
    );

    beat_packer u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_en_i  (beat_en),
        .beat_idx_i (beat_idx),
        .hrdata_i   (hrdata_i),
        .lane       (lane_wr.src)
    );

    // lane group out to the decoder ports
    assign decomp0_wren_o = lane_wr.wren0;
    assign decomp1_wren_o = lane_wr.wren1;
    assign decomp2_wren_o = lane_wr.wren2;
    assign decomp_sop_o   = lane_wr.sop;
    assign decomp_eop_o   = lane_wr.eop;
    assign decomp_wdata_o = lane_wr.wdata;

endmodule

`default_nettype wire

/* src/beat_packer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decomp_defs.svh"

module beat_packer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         beat_en_i,
    input  wire  [4:0]                  beat_idx_i,
    input  wire  [`DECOMP_DATA_W-1:0]   hrdata_i,
    lane_wr_if.src                      lane
);

    import decomp_pkg::*;

    lane_sel_e                  lane_sel;
    logic [`DECOMP_DATA_W-1:0]  upper;
    logic [`DECOMP_WORD_W-1:0]  wdata;
    logic                       wren0, wren1, wren2;
    logic                       sop, eop;
    logic                       odd_beat;

    assign odd_beat = beat_en_i && beat_idx_i[0];

    // --------------------
    // lane select
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_sel <= LANE0;
        end else if (beat_en_i && (beat_idx_i == 5'd0)) begin
            if (hrdata_i[31]) begin
                lane_sel <= LANE0;
            end else if (!hrdata_i[30]) begin
                lane_sel <= LANE1;
            end else begin
                lane_sel <= LANE2;
            end
        end
    end

    // strobes for one cycle after each odd beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wren0 <= 1'b0;
            wren1 <= 1'b0;
            wren2 <= 1'b0;
            sop   <= 1'b0;
            eop   <= 1'b0;
        end else begin
            wren0 <= odd_beat && (lane_sel == LANE0);
            wren1 <= odd_beat && (lane_sel == LANE1);
            wren2 <= odd_beat && (lane_sel == LANE2);
            sop   <= odd_beat && (beat_idx_i[3:1] == 3'd0);
            eop   <= odd_beat && (beat_idx_i[3:1] == 3'd7);
        end
    end

    // --------------------
    // word assembly
    // --------------------
    always_ff @(posedge clk) begin
        if (beat_en_i && !beat_idx_i[0]) begin
            upper <= hrdata_i;
        end
        if (odd_beat) begin
            wdata <= {upper, hrdata_i};
        end
    end

    assign lane.wren0 = wren0;
    assign lane.wren1 = wren1;
    assign lane.wren2 = wren2;
    assign lane.sop   = sop;
    assign lane.eop   = eop;
    assign lane.wdata = wdata;

endmodule

`default_nettype wire

/* src/ahb_burst_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decomp_defs.svh"

module ahb_burst_master (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [`DECOMP_ADDR_W-1:0]   src_addr_i,
    input  wire  [`DECOMP_ADDR_W-1:0]   dst_addr_i,
    input  wire  [`DECOMP_LEN_W-1:0]    len_i,
    input  wire                         start_i,
    input  wire                         decomp_done_i,
    input  wire  [`DECOMP_WORD_W-1:0]   decomp_data_i,
    input  wire                         hgrant_i,
    input  wire                         hready_i,
    output logic                        done_o,
    output logic                        hbusreq_o,
    output logic [`DECOMP_ADDR_W-1:0]   haddr_o,
    output decomp_pkg::ahb_trans_e      htrans_o,
    output logic                        hwrite_o,
    output logic [`DECOMP_DATA_W-1:0]   hwdata_o,
    output logic [`DECOMP_BUF_AW-1:0]   buf_addr_o,
    output logic                        beat_en_o,
    output logic [4:0]                  beat_idx_o
);

    import decomp_pkg::*;

    localparam logic [4:0] RD_LAST_IDX  = 5'(`DECOMP_BURST_BEATS - 2);
    localparam logic [4:0] WR1_LAST_IDX = 5'(`DECOMP_BURST_BEATS - 1);
    localparam logic [4:0] WR2_LAST_IDX = 5'(2 * `DECOMP_BURST_BEATS - 1);

    engine_state_e              state, state_n;
    logic [`DECOMP_LEN_W-1:0]   blk_cnt, blk_cnt_n;
    // data phase index in reads and address phase index 0..31 in writes
    logic [4:0]                 beat_cnt, beat_cnt_n;
    logic                       hbusreq, hbusreq_n;
    ahb_trans_e                 htrans, htrans_n;
    logic                       hwrite, hwrite_n;
    logic [`DECOMP_ADDR_W-1:0]  haddr, haddr_n;
    logic [`DECOMP_DATA_W-1:0]  hwdata, hwdata_n;
    logic [`DECOMP_DATA_W-1:0]  wr_half;
    logic                       beat_en;

    // even beats carry the upper half of the buffer word
    assign wr_half = beat_cnt[0] ? decomp_data_i[`DECOMP_DATA_W-1:0]
                                 : decomp_data_i[`DECOMP_WORD_W-1:`DECOMP_DATA_W];

    // --------------------
    // block loop FSM
    // --------------------
    always_comb begin
        state_n    = state;
        blk_cnt_n  = blk_cnt;
        beat_cnt_n = beat_cnt;
        hbusreq_n  = hbusreq;
        htrans_n   = htrans;
        hwrite_n   = hwrite;
        haddr_n    = haddr;
        hwdata_n   = hwdata;
        beat_en    = 1'b0;

        case (state)
            S_IDLE: begin
                if (start_i && (len_i != '0)) begin
                    blk_cnt_n = '0;
                    hbusreq_n = 1'b1;
                    state_n   = S_RD_REQ;
                end
            end
            S_RD_REQ: begin
                if (hgrant_i) begin
                    hbusreq_n = 1'b0;
                    haddr_n   = src_addr_i + {blk_cnt, {`DECOMP_BLK_SHIFT{1'b0}}};
                    htrans_n  = HTRANS_NONSEQ;
                    hwrite_n  = 1'b0;
                    state_n   = S_RD_ADDR;
                end
            end
            S_RD_ADDR: begin
                if (hready_i) begin
                    haddr_n    = haddr + `DECOMP_ADDR_W'(4);
                    htrans_n   = HTRANS_SEQ;
                    beat_cnt_n = '0;
                    state_n    = S_RD_MID;
                end
            end
            S_RD_MID: begin
                // address of beat n+1 and data of beat n together
                if (hready_i) begin
                    beat_en    = 1'b1;
                    beat_cnt_n = beat_cnt + 5'd1;
                    if (beat_cnt == RD_LAST_IDX) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_RD_LAST;
                    end else begin
                        haddr_n = haddr + `DECOMP_ADDR_W'(4);
                    end
                end
            end
            S_RD_LAST: begin
                if (hready_i) begin
                    beat_en = 1'b1;
                    state_n = S_DECOMP;
                end
            end
            S_DECOMP: begin
                if (decomp_done_i) begin
                    beat_cnt_n = '0;
                    hbusreq_n  = 1'b1;
                    state_n    = S_WR1_REQ;
                end
            end
            S_WR1_REQ: begin
                if (hgrant_i) begin
                    hbusreq_n = 1'b0;
                    // expanded block is twice the size
                    haddr_n   = dst_addr_i + {blk_cnt[`DECOMP_LEN_W-2:0],
                                              {(`DECOMP_BLK_SHIFT + 1){1'b0}}};
                    htrans_n  = HTRANS_NONSEQ;
                    hwrite_n  = 1'b1;
                    state_n   = S_WR1_ADDR;
                end
            end
            S_WR1_ADDR, S_WR2_ADDR: begin
                if (hready_i) begin
                    hwdata_n   = wr_half;
                    beat_cnt_n = beat_cnt + 5'd1;
                    haddr_n    = haddr + `DECOMP_ADDR_W'(4);
                    htrans_n   = HTRANS_SEQ;
                    state_n    = (state == S_WR1_ADDR) ? S_WR1_MID : S_WR2_MID;
                end
            end
            S_WR1_MID, S_WR2_MID: begin
                if (hready_i) begin
                    hwdata_n   = wr_half;
                    beat_cnt_n = beat_cnt + 5'd1;
                    // keeps counting into the second burst
                    haddr_n    = haddr + `DECOMP_ADDR_W'(4);
                    if ((state == S_WR1_MID) && (beat_cnt == WR1_LAST_IDX)) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_WR1_LAST;
                    end else if ((state == S_WR2_MID) && (beat_cnt == WR2_LAST_IDX)) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_WR2_LAST;
                    end
                end
            end
            S_WR1_LAST: begin
                if (hready_i) begin
                    hbusreq_n = 1'b1;
                    state_n   = S_WR2_REQ;
                end
            end
            S_WR2_REQ: begin
                if (hgrant_i) begin
                    hbusreq_n = 1'b0;
                    htrans_n  = HTRANS_NONSEQ;
                    state_n   = S_WR2_ADDR;
                end
            end
            S_WR2_LAST: begin
                if (hready_i) begin
                    blk_cnt_n = blk_cnt + 1'b1;
                    hwrite_n  = 1'b0;
                    if (blk_cnt_n == len_i) begin
                        state_n = S_IDLE;
                    end else begin
                        hbusreq_n = 1'b1;
                        state_n   = S_RD_REQ;
                    end
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            blk_cnt  <= '0;
            beat_cnt <= '0;
            hbusreq  <= 1'b0;
            htrans   <= HTRANS_IDLE;
            hwrite   <= 1'b0;
        end else begin
            state    <= state_n;
            blk_cnt  <= blk_cnt_n;
            beat_cnt <= beat_cnt_n;
            hbusreq  <= hbusreq_n;
            htrans   <= htrans_n;
            hwrite   <= hwrite_n;
        end
    end

    always_ff @(posedge clk) begin
        haddr  <= haddr_n;
        hwdata <= hwdata_n;
    end

    // --------------------
    // outputs
    // --------------------
    // start_i term keeps done low in the start cycle
    assign done_o     = (state == S_IDLE) && !start_i;
    assign hbusreq_o  = hbusreq;
    assign haddr_o    = haddr;
    assign htrans_o   = htrans;
    assign hwrite_o   = hwrite;
    assign hwdata_o   = hwdata;
    assign buf_addr_o = beat_cnt[4:1];
    assign beat_en_o  = beat_en;
    assign beat_idx_o = beat_cnt;

endmodule

`default_nettype wire

/* src/lane_wr_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decomp_defs.svh"

interface lane_wr_if;

    // one-cycle strobes without back-pressure
    logic                       wren0;
    logic                       wren1;
    logic                       wren2;
    logic                       sop;
    logic                       eop;
    logic [`DECOMP_WORD_W-1:0]  wdata;

    modport src (
        output wren0, wren1, wren2, sop, eop, wdata
    );

    modport dst (
        input  wren0, wren1, wren2, sop, eop, wdata
    );

endinterface

`default_nettype wire

/* src/decomp_pkg.sv */
`default_nettype none

`include "decomp_defs.svh"

package decomp_pkg;

    // one read burst, decoder wait, then two write bursts per block
    typedef enum logic [3:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_ADDR,
        S_RD_MID,
        S_RD_LAST,
        S_DECOMP,
        S_WR1_REQ,
        S_WR1_ADDR,
        S_WR1_MID,
        S_WR1_LAST,
        S_WR2_REQ,
        S_WR2_ADDR,
        S_WR2_MID,
        S_WR2_LAST
    } engine_state_e;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = `DECOMP_HTRANS_IDLE,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = `DECOMP_HTRANS_NONSEQ,
        HTRANS_SEQ    = `DECOMP_HTRANS_SEQ
    } ahb_trans_e;

    // decoder lane picked from the block header
    typedef enum logic [1:0] {
        LANE0,
        LANE1,
        LANE2
    } lane_sel_e;

endpackage

`default_nettype wire

/* src/decomp_defs.svh */
`ifndef DECOMP_DEFS_SVH
`define DECOMP_DEFS_SVH

// --------------------
// bus and data widths
// --------------------
`define DECOMP_ADDR_W       32
`define DECOMP_DATA_W       32
`define DECOMP_WORD_W       64
`define DECOMP_LEN_W        26

// --------------------
// block geometry
// --------------------
// 64 bytes per compressed block
`define DECOMP_BLK_SHIFT    6
`define DECOMP_BURST_BEATS  16
// sixteen 64-bit words in the output buffer
`define DECOMP_BUF_AW       4

// --------------------
// AHB transfer codes
// --------------------
`define DECOMP_HTRANS_IDLE   2'b00
`define DECOMP_HTRANS_NONSEQ 2'b10
`define DECOMP_HTRANS_SEQ    2'b11

`endif
